// File: tb.f
hdl/axil_pkg.sv
hdl/mul_pkg.sv
hdl/reg_if.sv
hdl/mul_if.sv
hdl/axil_slave.sv
hdl/mul_regs.sv
hdl/shift_add_mul.sv
hdl/mul_axil_top.sv
tests/mul_axil_chk.sv
tests/tb_mul_axil.sv

// File: Bender.yml
package:
  name: mul_axil

sources:
  - hdl/axil_pkg.sv
  - hdl/mul_pkg.sv
  - hdl/reg_if.sv
  - hdl/mul_if.sv
  - hdl/axil_slave.sv
  - hdl/mul_regs.sv
  - hdl/shift_add_mul.sv
  - hdl/mul_axil_top.sv
  - target: test
    files:
      - tests/mul_axil_chk.sv
      - tests/tb_mul_axil.sv

// File: tests/tb_mul_axil.sv
// testbench for mul_axil_top; one access in flight, tasks start and end on a falling edge
`timescale 1ns/100ps

module tb_mul_axil;

    localparam time clk_period = 100;
    localparam int  num_tests  = 32;
    localparam time run_limit  = (num_tests * (mul_pkg::mul_latency + 40) + 200) * clk_period;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [axil_pkg::addr_width-1:0] awaddr;
    logic                            awvalid;
    logic                            awready;
    logic [axil_pkg::data_width-1:0] wdata;
    logic [axil_pkg::strb_width-1:0] wstrb;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;
    logic [axil_pkg::addr_width-1:0] araddr;
    logic                            arvalid;
    logic                            arready;
    logic [axil_pkg::data_width-1:0] rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;

    mul_axil_top u_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int hold;
        hold    = $urandom_range(3, 0);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // accept shows as bvalid one edge later
        do @(negedge clk); while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int hold;
        hold    = $urandom_range(3, 0);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!rvalid);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        repeat (hold) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_ok(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] strb);
        logic [1:0] resp;
        bus_write(addr, data, strb, resp);
        check_value("bresp", axil_pkg::resp_okay, resp);
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        bus_read(addr, data, resp);
        check_value("rresp", axil_pkg::resp_okay, resp);
        check_value("rdata", exp, data);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        logic [1:0]  resp;
        status = '0;
        while (!status[axil_pkg::status_done_bit]) begin
            bus_read(axil_pkg::addr_ctrl, status, resp);
            check_value("rresp", axil_pkg::resp_okay, resp);
        end
    endtask

    task automatic multiply_and_check(input logic [15:0] mcand, input logic [15:0] mplier);
        write_ok(axil_pkg::addr_operands, {mplier, mcand}, 4'hf);
        write_ok(axil_pkg::addr_ctrl, 32'h1, 4'hf);
        wait_done();
        read_expect(axil_pkg::addr_product, 32'(mcand) * 32'(mplier));
    endtask

    // only strobed bytes take the new value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[8*b +: 8] = new_word[8*b +: 8];
        end
        return word;
    endfunction

    task automatic strobe_case(input logic [31:0] old_word, input logic [31:0] new_word,
                               input logic [3:0] strb);
        logic [31:0] merged;
        merged = merge_bytes(old_word, new_word, strb);
        write_ok(axil_pkg::addr_operands, old_word, 4'hf);
        write_ok(axil_pkg::addr_operands, new_word, strb);
        read_expect(axil_pkg::addr_operands, merged);
        write_ok(axil_pkg::addr_ctrl, 32'h1, 4'h1);
        wait_done();
        read_expect(axil_pkg::addr_product, 32'(merged[15:0]) * 32'(merged[31:16]));
    endtask

    initial begin
        #(run_limit);
        $display("timeout: tests did not finish within %0t ns", run_limit);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        wait (u_dut.u_chk.err_cnt != 0);
        $display("protocol or timing assertion failed at %0t ns", $time);
        $display("Simulation failed");
        $fatal(1, "checker assertion failed");
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        void'($urandom(32'h7f36));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_value("bvalid", 32'h0, 32'(bvalid));
            check_value("rvalid", 32'h0, 32'(rvalid));
            check_value("awready", 32'h0, 32'(awready));
            check_value("wready", 32'h0, 32'(wready));
            check_value("arready", 32'h0, 32'(arready));
        end
        rst_n = 1'b1;
        @(negedge clk);

        read_expect(axil_pkg::addr_ctrl, 32'h0);
        read_expect(axil_pkg::addr_operands, 32'h0);
        read_expect(axil_pkg::addr_product, 32'h0);

        multiply_and_check(16'h0000, 16'h8a3c);
        multiply_and_check(16'h7e21, 16'h0000);
        multiply_and_check(16'h0001, 16'hbeef);
        multiply_and_check(16'hffff, 16'hffff);
        multiply_and_check(16'hffff, 16'h0001);
        repeat (20) multiply_and_check(16'($urandom()), 16'($urandom()));

        // new operands and a second start during a run
        write_ok(axil_pkg::addr_operands, {16'h9c41, 16'h3b7d}, 4'hf);
        write_ok(axil_pkg::addr_ctrl, 32'h1, 4'hf);
        write_ok(axil_pkg::addr_operands, {16'h0005, 16'h0007}, 4'hf);
        write_ok(axil_pkg::addr_ctrl, 32'h1, 4'hf);
        wait_done();
        read_expect(axil_pkg::addr_product, 32'h3b7d * 32'h9c41);
        repeat (mul_pkg::mul_latency + 4) @(negedge clk);
        read_expect(axil_pkg::addr_ctrl, 32'h2);
        read_expect(axil_pkg::addr_product, 32'h3b7d * 32'h9c41);

        strobe_case(32'h1234_5678, 32'ha5c3_9e0f, 4'b0101);
        strobe_case(32'hfedc_ba98, 32'h0f00_4321, 4'b1010);

        // error responses leave the product alone
        multiply_and_check(16'h00c3, 16'h1d0a);
        bus_read(4'hc, data, resp);
        check_value("rresp", axil_pkg::resp_slverr, resp);
        check_value("rdata", 32'h0, data);
        bus_write(axil_pkg::addr_product, 32'hdead_beef, 4'hf, resp);
        check_value("bresp", axil_pkg::resp_slverr, resp);
        bus_write(4'hc, 32'h0000_0001, 4'hf, resp);
        check_value("bresp", axil_pkg::resp_slverr, resp);
        read_expect(axil_pkg::addr_product, 32'h00c3 * 32'h1d0a);

        @(negedge clk);
        if (u_dut.u_chk.err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

// File: tests/mul_axil_chk.sv
// bus and done timing checks bound into mul_axil_top; err_cnt counts failures for the testbench
`timescale 1ns/100ps

module mul_axil_chk (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            awvalid,
    input logic                            awready,
    input logic                            wvalid,
    input logic                            wready,
    input logic                            bvalid,
    input logic                            bready,
    input logic [1:0]                      bresp,
    input logic                            arvalid,
    input logic                            arready,
    input logic                            rvalid,
    input logic                            rready,
    input logic [axil_pkg::data_width-1:0] rdata,
    input logic [1:0]                      rresp,
    input logic                            start,
    input logic                            busy,
    input logic                            done
);

    int err_cnt = 0;

    // aw and w taken together when the b channel is free, response next cycle
    aw_w_accept: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && wvalid && !bvalid |-> awready && wready ##1 bvalid)
        else begin
            err_cnt++;
            $error("write not accepted with a free b channel");
        end

    ar_accept: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !rvalid |-> arready ##1 rvalid)
        else begin
            err_cnt++;
            $error("read not accepted with a free r channel");
        end

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            err_cnt++;
            $error("b channel changed while waiting for bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            err_cnt++;
            $error("r channel changed while waiting for rready");
        end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !bvalid && !rvalid)
        else begin
            err_cnt++;
            $error("response valid high during reset");
        end

    // busy only ends through the done state
    busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(done))
        else begin
            err_cnt++;
            $error("busy fell without done");
        end

    done_time: assert property (@(posedge clk) disable iff (!rst_n)
        start && !busy |-> ##(mul_pkg::mul_latency) done ##1 !done)
        else begin
            err_cnt++;
            $error("done not a single pulse at the fixed latency");
        end

endmodule

bind mul_axil_top mul_axil_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .start   (mul_bus.start),
    .busy    (mul_bus.busy),
    .done    (mul_bus.done)
);

// File: hdl/mul_axil_top.sv
// multiplier peripheral top; plain AXI4-Lite slave ports, one outstanding access per channel
`timescale 1ns/100ps

module mul_axil_top (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [axil_pkg::addr_width-1:0]    awaddr,
    input  logic                               awvalid,
    output logic                               awready,

    input  logic [axil_pkg::data_width-1:0]    wdata,
    input  logic [axil_pkg::strb_width-1:0]    wstrb,
    input  logic                               wvalid,
    output logic                               wready,

    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,

    input  logic [axil_pkg::addr_width-1:0]    araddr,
    input  logic                               arvalid,
    output logic                               arready,

    output logic [axil_pkg::data_width-1:0]    rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready
);

    reg_if reg_bus ();
    mul_if mul_bus ();

    axil_slave u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .regs    (reg_bus.master)
    );

    mul_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .regs  (reg_bus.slave),
        .mul   (mul_bus.master)
    );

    shift_add_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .mul   (mul_bus.slave)
    );

endmodule

// File: hdl/shift_add_mul.sv
// sequential unsigned multiplier; two cycles per multiplier bit, start dropped unless idle
`timescale 1ns/100ps

module shift_add_mul (
    input  logic clk,
    input  logic rst_n,
    mul_if.slave mul
);

    mul_pkg::mul_state_e                state_q;
    mul_pkg::mul_state_e                state_d;

    // extra top bit holds the carry of the add
    logic [mul_pkg::prod_width:0]       acc_q;
    logic [mul_pkg::op_width-1:0]       mplier_q;
    logic [mul_pkg::op_width-1:0]       mcand_q;
    logic [mul_pkg::cnt_width-1:0]      bit_cnt_q;
    logic [mul_pkg::prod_width-1:0]     product_q;
    logic                               last_bit;

    assign last_bit = (bit_cnt_q == mul_pkg::cnt_width'(mul_pkg::op_width - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mul_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mul_pkg::idle:  state_d = mul.start ? mul_pkg::init : mul_pkg::idle;
            mul_pkg::init:  state_d = mul_pkg::add;
            mul_pkg::add:   state_d = mul_pkg::shift;
            mul_pkg::shift: state_d = last_bit ? mul_pkg::done : mul_pkg::add;
            mul_pkg::done:  state_d = mul_pkg::idle;
            default:        state_d = mul_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q     <= '0;
            mplier_q  <= '0;
            mcand_q   <= '0;
            bit_cnt_q <= '0;
            product_q <= '0;
        end else begin
            case (state_q)
                mul_pkg::init: begin
                    // operands only sampled here
                    acc_q     <= '0;
                    mplier_q  <= mul.multiplier;
                    mcand_q   <= mul.multiplicand;
                    bit_cnt_q <= '0;
                end
                mul_pkg::add: begin
                    if (mplier_q[0]) begin
                        acc_q[mul_pkg::prod_width:mul_pkg::op_width] <=
                            acc_q[mul_pkg::prod_width:mul_pkg::op_width] + {1'b0, mcand_q};
                    end
                end
                mul_pkg::shift: begin
                    acc_q     <= {1'b0, acc_q[mul_pkg::prod_width:1]};
                    mplier_q  <= {1'b0, mplier_q[mul_pkg::op_width-1:1]};
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    // product lands as the FSM enters done
                    if (last_bit) begin
                        product_q <= acc_q[mul_pkg::prod_width:1];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign mul.busy    = (state_q != mul_pkg::idle);
    assign mul.done    = (state_q == mul_pkg::done);
    assign mul.product = product_q;

endmodule

// File: hdl/mul_regs.sv
// register block; start needs ctrl byte 0 strobed, product is read-only, no read side effects
`timescale 1ns/100ps

module mul_regs (
    input  logic  clk,
    input  logic  rst_n,
    reg_if.slave  regs,
    mul_if.master mul
);

    mul_pkg::operand_word_u             opnd_q;
    logic                               start_q;
    logic                               done_q;
    logic [mul_pkg::prod_width-1:0]     prod_q;

    logic                               wr_ctrl;
    logic                               wr_opnd;
    logic                               start_wr;
    logic                               done_now;
    logic [mul_pkg::prod_width-1:0]     prod_now;
    logic [axil_pkg::data_width-1:0]    status;

    assign wr_ctrl  = regs.wr_en && (regs.wr_addr == axil_pkg::addr_ctrl);
    assign wr_opnd  = regs.wr_en && (regs.wr_addr == axil_pkg::addr_operands);
    assign start_wr = wr_ctrl && regs.wr_strb[0] && regs.wr_data[axil_pkg::ctrl_start_bit];

    // access errors
    assign regs.wr_err = regs.wr_en && !(regs.wr_addr == axil_pkg::addr_ctrl ||
                                         regs.wr_addr == axil_pkg::addr_operands);
    assign regs.rd_err = regs.rd_en && !(regs.rd_addr == axil_pkg::addr_ctrl ||
                                         regs.rd_addr == axil_pkg::addr_operands ||
                                         regs.rd_addr == axil_pkg::addr_product);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opnd_q.raw <= '0;
            start_q    <= 1'b0;
            done_q     <= 1'b0;
            prod_q     <= '0;
        end else begin
            start_q <= start_wr;
            // byte strobe merge
            if (wr_opnd) begin
                for (int b = 0; b < axil_pkg::strb_width; b++) begin
                    if (regs.wr_strb[b]) begin
                        opnd_q.raw[8*b +: 8] <= regs.wr_data[8*b +: 8];
                    end
                end
            end
            // a new start wins over a finishing run
            if (start_wr) begin
                done_q <= 1'b0;
            end else if (mul.done) begin
                done_q <= 1'b1;
            end
            if (mul.done) begin
                prod_q <= mul.product;
            end
        end
    end

    // done cycle visible without waiting for the capture
    assign done_now = done_q || mul.done;
    assign prod_now = mul.done ? mul.product : prod_q;

    always_comb begin
        status = '0;
        status[axil_pkg::status_busy_bit] = mul.busy;
        status[axil_pkg::status_done_bit] = done_now;
    end

    always_comb begin
        case (regs.rd_addr)
            axil_pkg::addr_ctrl:     regs.rd_data = status;
            axil_pkg::addr_operands: regs.rd_data = opnd_q.raw;
            axil_pkg::addr_product:  regs.rd_data = prod_now;
            default:                 regs.rd_data = '0;
        endcase
    end

    assign mul.start        = start_q;
    assign mul.multiplicand = opnd_q.fields.multiplicand;
    assign mul.multiplier   = opnd_q.fields.multiplier;

endmodule

// File: hdl/axil_slave.sv
// AXI4-Lite slave; one transaction per channel, aw and w must arrive together, ready depends on valid
`timescale 1ns/100ps

module axil_slave (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [axil_pkg::addr_width-1:0]    awaddr,
    input  logic                               awvalid,
    output logic                               awready,

    input  logic [axil_pkg::data_width-1:0]    wdata,
    input  logic [axil_pkg::strb_width-1:0]    wstrb,
    input  logic                               wvalid,
    output logic                               wready,

    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,

    input  logic [axil_pkg::addr_width-1:0]    araddr,
    input  logic                               arvalid,
    output logic                               arready,

    output logic [axil_pkg::data_width-1:0]    rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,

    reg_if.master                              regs
);

    logic wr_accept;
    logic rd_accept;

    // pending response blocks the next accept
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // one-cycle access toward the register block
    assign regs.wr_en   = wr_accept;
    assign regs.wr_addr = awaddr;
    assign regs.wr_data = wdata;
    assign regs.wr_strb = wstrb;

    assign regs.rd_en   = rd_accept;
    assign regs.rd_addr = araddr;

    // write response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            bresp  <= axil_pkg::resp_okay;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            bresp  <= regs.wr_err ? axil_pkg::resp_slverr : axil_pkg::resp_okay;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // read response, data captured in the accept cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rresp  <= axil_pkg::resp_okay;
            rdata  <= '0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
            if (regs.rd_err) begin
                rresp <= axil_pkg::resp_slverr;
                rdata <= '0;
            end else begin
                rresp <= axil_pkg::resp_okay;
                rdata <= regs.rd_data;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

// File: hdl/mul_if.sv
// multiplier command and result; start is a single-cycle pulse, ignored while busy
`timescale 1ns/100ps

interface mul_if;

    logic                            start;
    logic [mul_pkg::op_width-1:0]    multiplicand;
    logic [mul_pkg::op_width-1:0]    multiplier;
    logic                            busy;
    logic                            done;
    logic [mul_pkg::prod_width-1:0]  product;

    modport master (
        output start, multiplicand, multiplier,
        input  busy, done, product
    );

    modport slave (
        input  start, multiplicand, multiplier,
        output busy, done, product
    );

endinterface

// File: hdl/reg_if.sv
// decoded register access; one-cycle strobes, read data and errors valid in the same cycle
`timescale 1ns/100ps

interface reg_if;

    // write side
    logic                                 wr_en;
    logic [axil_pkg::addr_width-1:0]      wr_addr;
    logic [axil_pkg::data_width-1:0]      wr_data;
    logic [axil_pkg::strb_width-1:0]      wr_strb;
    logic                                 wr_err;

    // read side
    logic                                 rd_en;
    logic [axil_pkg::addr_width-1:0]      rd_addr;
    logic [axil_pkg::data_width-1:0]      rd_data;
    logic                                 rd_err;

    modport master (
        output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        input  rd_data, wr_err, rd_err
    );

    modport slave (
        input  wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        output rd_data, wr_err, rd_err
    );

endinterface

// File: hdl/mul_pkg.sv
// multiplier constants and types; unsigned operands only, width fixed at build time
package mul_pkg;

    localparam int op_width   = 16;
    localparam int prod_width = 2 * op_width;

    // bit counter covers op_width steps
    localparam int cnt_width = $clog2(op_width);

    // start seen in idle to done high
    localparam int mul_latency = 2 * op_width + 2;

    typedef enum logic [2:0] {
        idle  = 3'd0,
        init  = 3'd1,
        add   = 3'd2,
        shift = 3'd3,
        done  = 3'd4
    } mul_state_e;

    // multiplier in the upper half, multiplicand in the lower
    typedef struct packed {
        logic [op_width-1:0] multiplier;
        logic [op_width-1:0] multiplicand;
    } operand_fields_t;

    // raw view for byte merging, field view for the datapath
    typedef union packed {
        logic [prod_width-1:0] raw;
        operand_fields_t       fields;
    } operand_word_u;

endpackage

// File: hdl/axil_pkg.sv
// register port constants; 4-bit byte addresses, word access only, unmapped offsets give slverr
package axil_pkg;

    // bus widths
    localparam int addr_width = 4;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // register map
    localparam logic [addr_width-1:0] addr_ctrl     = 4'h0;
    localparam logic [addr_width-1:0] addr_operands = 4'h4;
    localparam logic [addr_width-1:0] addr_product  = 4'h8;

    // ctrl write bit and status read bits
    localparam int ctrl_start_bit  = 0;
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

    // responses, exokay and decerr never produced
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage
